//--- hdl/cadr_settings.svh
`ifndef CADR_SETTINGS_SVH
`define CADR_SETTINGS_SVH

// Micro-instruction word as fetched from control memory.
`define CADR_IR_WIDTH 49

// Obus and M-functional bus width.
`define CADR_DATA_WIDTH 32

// PDL pointer and index width.
`define CADR_PDL_WIDTH 10

// Location counter bits shown on an LC read, interrupt control above.
`define CADR_LC_WIDTH 26

`endif

//--- hdl/cadr_pkg.sv
`include "cadr_settings.svh"

package cadr_pkg;

   typedef logic [`CADR_IR_WIDTH-1:0]   ir_t;       // Micro-instruction word.
   typedef logic [`CADR_DATA_WIDTH-1:0] word_t;     // Obus / M-functional data.
   typedef logic [`CADR_PDL_WIDTH-1:0]  pdl_addr_t; // PDL pointer or index.
   typedef logic [3:0]                  funct_t;    // One-hot ALU function group.

   typedef struct packed {
      logic iralu;  // ALU instruction.
      logic irjump; // Jump instruction.
      logic irdisp; // Dispatch instruction.
      logic irbyte; // Byte instruction.
   } op_class_t;

   typedef struct packed {
      logic srcdc;     // Dispatch constant.
      logic srcspc;    // SPC pointer and data.
      logic srcpdlptr; // PDL pointer.
      logic srcpdlidx; // PDL index.
      logic srcpdltop; // PDL buffer at index.
      logic srcopc;    // OPC registers.
      logic srcq;      // Q register.
      logic srcvma;    // VMA.
      logic srcmap;    // Map of MD.
      logic srcmd;     // MD.
      logic srclc;     // Location counter.
      logic srcspcpop; // SPC, pop.
      logic srcpdlpop; // PDL buffer at pointer, pop.
   } src_sel_t;

   typedef struct packed {
      logic dest;       // Class can write a destination.
      logic destm;      // Destination field enabled.
      logic destmem;    // Memory destination group.
      logic destvma;    // VMA.
      logic destmdr;    // MD.
      logic destlc;     // Location counter.
      logic destintctl; // Interrupt control.
      logic destpdltop; // PDL buffer at pointer.
      logic destpdl_p;  // PDL buffer at pointer, push.
      logic destpdl_x;  // PDL buffer at index.
      logic destpdlx;   // PDL index.
      logic destpdlp;   // PDL pointer.
      logic destspc;    // SPC, push.
      logic destimod0;  // OA register, low half.
      logic destimod1;  // OA register, high half.
   } dest_sel_t;

   typedef struct packed {
      op_class_t op;    // Operation class.
      funct_t    funct; // ALU function group.
      logic      mul;   // Multiply step.
      logic      div;   // Divide step.
      logic      imod;  // Next instruction modified.
      src_sel_t  src;   // M-functional source selects.
      dest_sel_t dst;   // Destination selects.
   } decode_t;

   typedef struct packed {
      ir_t   ir;      // Instruction.
      word_t obus;    // Value to write.
      logic  nop;     // Suppress execution.
      logic  idebug;  // Debug load of IR.
      logic  iwrited; // Write of control memory.
   } uinst_t;

   typedef struct packed {
      decode_t dec; // Decoded fields.
      word_t   mf;  // Source value before the write.
   } result_t;

   typedef enum logic [1:0] {
      IDLE,     // Waiting for in_req.
      EXEC,     // One execute cycle.
      OUT_REQ,  // Result offered, waiting for res_ack.
      OUT_DONE  // Waiting for in_req and res_ack low.
   } port_state_e;

endpackage

//--- hdl/source_decode.sv
`timescale 1ns/1ps

module source_decode (
   input  cadr_pkg::ir_t     ir,
   input  logic              nop,
   input  logic              idebug,
   input  logic              iwrited,
   output cadr_pkg::decode_t dec
);

   logic specalu; // Special ALU op in ALU class.

   always_comb begin
      dec = '0; // Nothing selected.

      if (!nop) begin
         case (ir[44:43]) // Operation class.
            2'b00:   dec.op.iralu  = 1'b1;
            2'b01:   dec.op.irjump = 1'b1;
            2'b10:   dec.op.irdisp = 1'b1;
            default: dec.op.irbyte = 1'b1;
         endcase
         dec.funct = cadr_pkg::funct_t'(4'b0001 << ir[11:10]); // One-hot group.
      end

      specalu = ir[8] & dec.op.iralu;
      dec.mul = specalu & (ir[4:3] == 2'b00); // Code 0 multiplies.
      dec.div = specalu & (ir[4:3] != 2'b00); // Others divide.

      if (ir[31] & ~ir[29]) begin // First source bank.
         case (ir[28:26])
            3'd0:    dec.src.srcdc     = 1'b1;
            3'd1:    dec.src.srcspc    = 1'b1;
            3'd2:    dec.src.srcpdlptr = 1'b1;
            3'd3:    dec.src.srcpdlidx = 1'b1;
            3'd4:    dec.src.srcpdlpop = 1'b1;
            3'd5:    dec.src.srcpdltop = 1'b1;
            3'd6:    dec.src.srcopc    = 1'b1;
            default: dec.src.srcq      = 1'b1;
         endcase
      end
      if (ir[31] & ir[29]) begin // Second source bank.
         case (ir[28:26])
            3'd0:    dec.src.srcvma    = 1'b1;
            3'd1:    dec.src.srcmap    = 1'b1;
            3'd2:    dec.src.srcmd     = 1'b1;
            3'd3:    dec.src.srclc     = 1'b1;
            3'd4:    dec.src.srcspcpop = 1'b1;
            default: ; // Unused codes.
         endcase
      end

      dec.dst.dest    = dec.op.iralu | dec.op.irbyte; // Only these write.
      dec.dst.destm   = dec.dst.dest & ~ir[25];       // A-only write clears it.
      dec.dst.destmem = dec.dst.destm & ir[23];
      dec.dst.destvma = dec.dst.destmem & ~ir[22];
      dec.dst.destmdr = dec.dst.destmem & ir[22];

      if (dec.dst.destm & ~ir[23] & ~ir[22]) begin // LC bank.
         case (ir[21:19])
            3'd1:    dec.dst.destlc     = 1'b1;
            3'd2:    dec.dst.destintctl = 1'b1;
            default: ; // No register.
         endcase
      end
      if (dec.dst.destm & ~ir[23] & ir[22]) begin // PDL, SPC and OA bank.
         case (ir[21:19])
            3'd0:    dec.dst.destpdltop = 1'b1;
            3'd1:    dec.dst.destpdl_p  = 1'b1;
            3'd2:    dec.dst.destpdl_x  = 1'b1;
            3'd3:    dec.dst.destpdlx   = 1'b1;
            3'd4:    dec.dst.destpdlp   = 1'b1;
            3'd5:    dec.dst.destspc    = 1'b1;
            3'd6:    dec.dst.destimod0  = 1'b1;
            default: dec.dst.destimod1  = 1'b1;
         endcase
      end

      // Next instruction is altered by OA writes or by the debug paths.
      dec.imod = dec.dst.destimod0 | dec.dst.destimod1 | iwrited | idebug;
   end

endmodule

//--- hdl/uinst_port.sv
`timescale 1ns/1ps

module uinst_port (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              in_req,
   input  cadr_pkg::uinst_t  in_data,
   output logic              in_ack,
   output cadr_pkg::uinst_t  cur,
   output logic              exec,
   input  cadr_pkg::decode_t dec,
   input  cadr_pkg::word_t   mf,
   output logic              res_req,
   input  logic              res_ack,
   output cadr_pkg::result_t res_data
);

   cadr_pkg::port_state_e state; // Handshake FSM.

   assign exec = (state == cadr_pkg::EXEC); // High for the one EXEC cycle.

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= cadr_pkg::IDLE;
         in_ack  <= 1'b0;
         res_req <= 1'b0;
      end else begin
         case (state)
            cadr_pkg::IDLE: begin
               if (in_req) begin
                  state <= cadr_pkg::EXEC; // Word captured this edge.
               end
            end
            cadr_pkg::EXEC: begin
               res_req <= 1'b1; // Result registered this edge.
               in_ack  <= 1'b1;
               state   <= cadr_pkg::OUT_REQ;
            end
            cadr_pkg::OUT_REQ: begin
               if (res_ack) begin
                  res_req <= 1'b0; // Receiver has the result.
                  state   <= cadr_pkg::OUT_DONE;
               end
            end
            default: begin
               if (!in_req && !res_ack) begin
                  in_ack <= 1'b0; // Both sides back to rest.
                  state  <= cadr_pkg::IDLE;
               end
            end
         endcase
      end
   end

   // Held word for decode and register write.
   always_ff @(posedge clk) begin
      if (state == cadr_pkg::IDLE && in_req) begin
         cur <= in_data;
      end
   end

   // Result stays stable while res_req is high.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res_data <= '0;
      end else if (exec) begin
         res_data.dec <= dec;
         res_data.mf  <= mf; // Value before this write.
      end
   end

endmodule

//--- hdl/func_regs.sv
`timescale 1ns/1ps
`include "cadr_settings.svh"

module func_regs (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                exec,
   input  cadr_pkg::src_sel_t  src,
   input  cadr_pkg::dest_sel_t dst,
   input  cadr_pkg::word_t     obus,
   output cadr_pkg::word_t     mf
);

   cadr_pkg::word_t     lc;      // Location counter.
   cadr_pkg::word_t     vma;     // Virtual memory address.
   cadr_pkg::word_t     md;      // Memory data.
   cadr_pkg::word_t     intctl;  // Interrupt control.
   cadr_pkg::pdl_addr_t pdl_ptr; // PDL pointer.
   cadr_pkg::pdl_addr_t pdl_idx; // PDL index.

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lc      <= '0;
         vma     <= '0;
         md      <= '0;
         intctl  <= '0;
         pdl_ptr <= '0;
         pdl_idx <= '0;
      end else if (exec) begin
         if (dst.destlc) begin
            lc <= obus;
         end
         if (dst.destvma) begin
            vma <= obus;
         end
         if (dst.destmdr) begin
            md <= obus;
         end
         if (dst.destintctl) begin
            intctl <= obus;
         end
         if (dst.destpdlp) begin
            pdl_ptr <= obus[`CADR_PDL_WIDTH-1:0]; // Low bits only.
         end
         if (dst.destpdlx) begin
            pdl_idx <= obus[`CADR_PDL_WIDTH-1:0];
         end
      end
   end

   // Source mux reads the registers as they stand before the write.
   always_comb begin
      mf = '0; // Unimplemented sources read zero.
      if (src.srclc) begin
         // LC read shows interrupt control bits above the counter.
         mf = {intctl[`CADR_DATA_WIDTH-1:`CADR_LC_WIDTH], lc[`CADR_LC_WIDTH-1:0]};
      end
      if (src.srcvma) begin
         mf = vma;
      end
      if (src.srcmd) begin
         mf = md;
      end
      if (src.srcpdlptr) begin
         mf = cadr_pkg::word_t'(pdl_ptr); // Zero-extended.
      end
      if (src.srcpdlidx) begin
         mf = cadr_pkg::word_t'(pdl_idx);
      end
   end

endmodule

//--- hdl/micro_decode_top.sv
`timescale 1ns/1ps

module micro_decode_top (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              in_req,
   input  cadr_pkg::uinst_t  in_data,
   output logic              in_ack,
   output logic              res_req,
   input  logic              res_ack,
   output cadr_pkg::result_t res_data
);

   cadr_pkg::uinst_t  cur;  // Held micro-instruction.
   logic              exec; // Execute strobe.
   cadr_pkg::decode_t dec;  // Decoder output.
   cadr_pkg::word_t   mf;   // M-functional read.

   uinst_port u_port (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_req   (in_req),
      .in_data  (in_data),
      .in_ack   (in_ack),
      .cur      (cur),
      .exec     (exec),
      .dec      (dec),
      .mf       (mf),
      .res_req  (res_req),
      .res_ack  (res_ack),
      .res_data (res_data)
   );

   source_decode u_decode (
      .ir      (cur.ir),
      .nop     (cur.nop),
      .idebug  (cur.idebug),
      .iwrited (cur.iwrited),
      .dec     (dec)
   );

   func_regs u_regs (
      .clk    (clk),
      .arst_n (arst_n),
      .exec   (exec),
      .src    (dec.src),
      .dst    (dec.dst),
      .obus   (cur.obus),
      .mf     (mf)
   );

endmodule

//--- verification/micro_decode_tb.sv
`timescale 1ns/1ps
`include "cadr_settings.svh"

module micro_decode_tb;

   logic                clk;
   logic                arst_n;
   logic                in_req;
   cadr_pkg::uinst_t    in_data;
   logic                in_ack;
   logic                res_req;
   logic                res_ack;
   cadr_pkg::result_t   res_data;

   logic [31:0]         rng = 32'h1963471f;   // Xorshift state.
   cadr_pkg::result_t   exp_q[$];             // Results still owed by the DUT.
   string               name_q[$];            // Test name per owed result.
   int                  sent = 0;             // Words accepted by the DUT.
   int                  rx_count = 0;         // Results fully handshaken.
   int                  ack_falls = 0;        // in_ack falling edges seen.
   logic                prev_ack = 1'b0;
   // Shadow of the functional registers.
   cadr_pkg::word_t     m_lc, m_vma, m_md, m_intctl;
   cadr_pkg::pdl_addr_t m_pdlp, m_pdlx;

   micro_decode_top DUT (
      .clk(clk), .arst_n(arst_n), .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
      .res_req(res_req), .res_ack(res_ack), .res_data(res_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk; // 8 ns period.
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Fields placed at their bit positions in the micro-instruction.
   function automatic cadr_pkg::ir_t build_ir(input logic [1:0] cls, input logic [1:0] fn,
         input logic spec, input logic [1:0] mdsel, input logic src_en,
         input logic [3:0] src_code, input logic a_only, input logic [1:0] grp,
         input logic [2:0] didx);
      cadr_pkg::ir_t ir;
      ir = '0;
      ir[44:43] = cls;
      ir[11:10] = fn;
      ir[8]     = spec;
      ir[4:3]   = mdsel;
      ir[31]    = src_en;
      ir[29]    = src_code[3];   // Bank.
      ir[28:26] = src_code[2:0]; // Index in bank.
      ir[25]    = a_only;
      ir[23:22] = grp;
      ir[21:19] = didx;
      return ir;
   endfunction

   // Reference decode of one word.
   function automatic cadr_pkg::decode_t ref_decode(input cadr_pkg::uinst_t u);
      cadr_pkg::decode_t d;
      logic              wr;
      d = '0;
      if (!u.nop) begin
         d.op                 = cadr_pkg::op_class_t'(4'b1000 >> u.ir[44:43]);
         d.funct[u.ir[11:10]] = 1'b1;
      end
      d.mul = d.op.iralu & u.ir[8] & (u.ir[4:3] == 2'b00);
      d.div = d.op.iralu & u.ir[8] & (u.ir[4:3] != 2'b00);
      if (u.ir[31]) begin
         case ({u.ir[29], u.ir[28:26]})
            4'h0: d.src.srcdc     = 1'b1;
            4'h1: d.src.srcspc    = 1'b1;
            4'h2: d.src.srcpdlptr = 1'b1;
            4'h3: d.src.srcpdlidx = 1'b1;
            4'h4: d.src.srcpdlpop = 1'b1;
            4'h5: d.src.srcpdltop = 1'b1;
            4'h6: d.src.srcopc    = 1'b1;
            4'h7: d.src.srcq      = 1'b1;
            4'h8: d.src.srcvma    = 1'b1;
            4'h9: d.src.srcmap    = 1'b1;
            4'ha: d.src.srcmd     = 1'b1;
            4'hb: d.src.srclc     = 1'b1;
            4'hc: d.src.srcspcpop = 1'b1;
            default: ;
         endcase
      end
      d.dst.dest  = d.op.iralu | d.op.irbyte;
      wr          = d.dst.dest & ~u.ir[25];
      d.dst.destm = wr;
      if (wr) begin
         case ({u.ir[23:22], u.ir[21:19]})
            5'b00001: d.dst.destlc     = 1'b1;
            5'b00010: d.dst.destintctl = 1'b1;
            5'b01000: d.dst.destpdltop = 1'b1;
            5'b01001: d.dst.destpdl_p  = 1'b1;
            5'b01010: d.dst.destpdl_x  = 1'b1;
            5'b01011: d.dst.destpdlx   = 1'b1;
            5'b01100: d.dst.destpdlp   = 1'b1;
            5'b01101: d.dst.destspc    = 1'b1;
            5'b01110: d.dst.destimod0  = 1'b1;
            5'b01111: d.dst.destimod1  = 1'b1;
            default: ;
         endcase
         d.dst.destmem = u.ir[23];
         d.dst.destvma = u.ir[23] & ~u.ir[22];
         d.dst.destmdr = u.ir[23] & u.ir[22];
      end
      d.imod = d.dst.destimod0 | d.dst.destimod1 | u.idebug | u.iwrited;
      return d;
   endfunction

   function automatic cadr_pkg::word_t ref_read(input cadr_pkg::src_sel_t s);
      if (s.srclc) return {m_intctl[31:`CADR_LC_WIDTH], m_lc[`CADR_LC_WIDTH-1:0]};
      if (s.srcvma) return m_vma;
      if (s.srcmd) return m_md;
      if (s.srcpdlptr) return {22'd0, m_pdlp};
      if (s.srcpdlidx) return {22'd0, m_pdlx};
      return '0; // Sources outside this stage.
   endfunction

   task automatic give_up(input string what);
      $display("%s", what);
      $display("Testbench failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
      if (exp !== act) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         give_up("first error reached");
      end
   endtask

   task automatic wait_in_ack(input logic lvl);
      int n;
      for (n = 0; in_ack !== lvl; n++) begin
         if (n > 200) give_up("timeout waiting for in_ack to change");
         @(negedge clk);
      end
   endtask

   task automatic wait_res_req(input logic lvl);
      int n;
      for (n = 0; res_req !== lvl; n++) begin
         if (n > 200) give_up("timeout waiting for res_req to change");
         @(negedge clk);
      end
   endtask

   // Queue the expected result, update the model, run the input handshake.
   task automatic send_word(input string name, input cadr_pkg::uinst_t u);
      cadr_pkg::result_t e;
      e.dec = ref_decode(u);
      e.mf  = ref_read(e.dec.src); // Read before write.
      exp_q.push_back(e);
      name_q.push_back(name);
      if (e.dec.dst.destlc) m_lc = u.obus;
      if (e.dec.dst.destvma) m_vma = u.obus;
      if (e.dec.dst.destmdr) m_md = u.obus;
      if (e.dec.dst.destintctl) m_intctl = u.obus;
      if (e.dec.dst.destpdlp) m_pdlp = u.obus[9:0]; // Truncated.
      if (e.dec.dst.destpdlx) m_pdlx = u.obus[9:0];
      @(posedge clk);
      in_req  <= 1'b1;
      in_data <= u;
      wait_in_ack(1'b1);
      @(posedge clk);
      in_req <= 1'b0;
      wait_in_ack(1'b0);
      sent++;
   endtask

   function automatic cadr_pkg::uinst_t make_word(input cadr_pkg::ir_t ir,
         input cadr_pkg::word_t obus, input logic [2:0] flags);
      cadr_pkg::uinst_t u;
      u.ir      = ir;
      u.obus    = obus;
      u.nop     = flags[2];
      u.idebug  = flags[1];
      u.iwrited = flags[0];
      return u;
   endfunction

   // Receiver with random back-pressure; compares every offered result.
   initial begin
      cadr_pkg::result_t e;
      string             n;
      int                delay;
      forever begin
         @(negedge clk);
         if (res_req && !res_ack) begin
            if (exp_q.size() == 0) give_up("result offered with nothing outstanding");
            e = exp_q.pop_front();
            n = name_q.pop_front();
            check({n, " dec"}, 128'(e.dec), 128'(res_data.dec));
            check({n, " mf"}, 128'(e.mf), 128'(res_data.mf));
            delay = int'(next_rand() % 8);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            res_ack <= 1'b1;
            wait_res_req(1'b0);
            @(posedge clk);
            res_ack <= 1'b0;
            rx_count++;
         end
      end
   end

   // in_ack may only fall once the output transfer has fully completed.
   always @(negedge clk) begin
      if (prev_ack && !in_ack) begin
         if (rx_count <= ack_falls || res_ack) give_up("in_ack fell before res_ack completed");
         ack_falls++;
      end
      prev_ack = in_ack;
   end

   initial begin
      int                i;
      int                n;
      logic [3:0]        src_codes[6];
      logic [4:0]        dst_codes[6];
      cadr_pkg::word_t   v;
      in_req  = 1'b0;
      in_data = '0;
      res_ack = 1'b0;
      arst_n  = 1'b0;
      {m_lc, m_vma, m_md, m_intctl} = '0;
      {m_pdlp, m_pdlx} = '0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check("reset in_ack", 128'd0, 128'(in_ack));
      check("reset res_req", 128'd0, 128'(res_req));
      check("reset res_data", 128'd0, 128'(res_data));
      src_codes = '{4'hb, 4'h8, 4'ha, 4'h2, 4'h3, 4'hb}; // LC, VMA, MD, PDLP, PDLX, intctl.
      dst_codes = '{5'b00001, 5'b10000, 5'b11000, 5'b01100, 5'b01011, 5'b00010};
      for (i = 0; i < 6; i++)
         send_word("reset read", make_word(build_ir(0, 0, 0, 0, 1, src_codes[i], 1, 0, 0),
                   next_rand(), 3'b000));
      for (i = 0; i < 64; i++)
         send_word("class funct", make_word(build_ir(i[1:0], i[3:2], i[4], 2'(next_rand()),
                   0, 0, 1, 0, 0), next_rand(), {i[5], 2'b00}));
      for (i = 0; i < 13; i++)
         send_word("source code", make_word(build_ir(0, 0, 0, 0, 1, i[3:0], 1, 0, 0),
                   next_rand(), 3'b000));
      // Both functional banks, then VMA and MDR.
      for (i = 0; i < 18; i++)
         send_word("dest code", make_word(build_ir(i[0] ? 2'd3 : 2'd0, 0, 0, 0, 0, 0, 0,
                   (i < 16) ? i[4:3] : {1'b1, i[0]}, i[2:0]),
                   next_rand(), {1'b0, i[1:0]}));
      for (i = 0; i < 6; i++) begin
         v = next_rand();
         send_word("write", make_word(build_ir(0, 0, 0, 0, 0, 0, 0, dst_codes[i][4:3],
                   dst_codes[i][2:0]), v, 3'b000));
         send_word("read back", make_word(build_ir(0, 0, 0, 0, 1, src_codes[i], 1, 0, 0),
                   next_rand(), 3'b000));
         send_word("read old", make_word(build_ir(0, 0, 0, 0, 1, src_codes[i], 0,
                   dst_codes[i][4:3], dst_codes[i][2:0]), next_rand(), 3'b000));
      end
      for (i = 0; i < 400; i++)
         send_word("soak", make_word(cadr_pkg::ir_t'({next_rand(), next_rand()}), next_rand(),
                   3'(next_rand() & next_rand())));
      for (n = 0; ack_falls != sent; n++) begin
         if (n > 500) give_up("timeout waiting for the last results");
         @(negedge clk);
      end
      if (exp_q.size() != 0 || rx_count != sent) give_up("result count does not match input");
      $display("Testbench passed");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+hdl
hdl/cadr_pkg.sv
hdl/source_decode.sv
hdl/uinst_port.sv
hdl/func_regs.sv
hdl/micro_decode_top.sv
verification/micro_decode_tb.sv

//--- Makefile
TOP       ?= micro_decode_tb
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing

SRCS := $(filter-out +%,$(shell cat filelist.f)) hdl/cadr_settings.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) filelist.f
	$(VERILATOR) $(VFLAGS) -f filelist.f --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@if grep -q "Testbench failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
